/* common/uvi_consts.svh */
// Widths, sync frame count, rate window length and gray weights
`ifndef UVI_CONSTS_SVH
`define UVI_CONSTS_SVH

// ==============================
// Data widths
// ==============================

// One colour channel, also gray
`define UVI_PIX_W 8
// Column and row counters
`define UVI_COORD_W 12
// Frames per window counter
`define UVI_CNT_W 32

// ==============================
// Stream control
// ==============================

// Frame ends to skip after reset
`define UVI_SYNC_FRAMES 2
// One second at 50 MHz
`define UVI_RATE_PERIOD 50000000

// Gray weights, sum of weights is 1 << shift
`define UVI_GRAY_WR 1
`define UVI_GRAY_WG 2
`define UVI_GRAY_WB 1
`define UVI_GRAY_SHIFT 2

`endif

/* common/uvi_pkg.sv */
// Package with pixel, sensor bus, mono beat and threshold structs and the sync state enum
`include "uvi_consts.svh"

package uvi_pkg;

  // ==============================
  // Pixel data
  // ==============================

  // 24-bit RGB, red in the top byte
  typedef struct packed {
    logic [`UVI_PIX_W-1:0] red;
    logic [`UVI_PIX_W-1:0] green;
    logic [`UVI_PIX_W-1:0] blue;
  } rgb_pixel_t;

  // Raw sensor bus, one sample per cycle
  typedef struct packed {
    logic       frame_valid;
    logic       line_valid;
    rgb_pixel_t rgb;
  } cam_bus_t;

  // Captured pixel with its coordinates
  // frame_valid only high inside a captured frame
  typedef struct packed {
    logic                    valid;
    logic                    frame_valid;
    logic [`UVI_COORD_W-1:0] x;
    logic [`UVI_COORD_W-1:0] y;
    rgb_pixel_t              rgb;
  } pixel_beat_t;

  // Single channel beat, gray or binary
  typedef struct packed {
    logic                  valid;
    logic [`UVI_PIX_W-1:0] value;
  } mono_beat_t;

  // Inclusive gray window
  typedef struct packed {
    logic [`UVI_PIX_W-1:0] low;
    logic [`UVI_PIX_W-1:0] high;
  } threshold_cfg_t;

  // ==============================
  // State encodings
  // ==============================

  typedef enum logic [0:0] {
    WAIT_EOF,
    PASS
  } sync_state_e;

endpackage

/* capture/camera_capture.sv */
// Sensor bus register, whole-frame capture gate, x/y counters and frame_done pulse
`timescale 1ns/1ns
`include "uvi_consts.svh"

module camera_capture (
  input  logic                 CLOCK_50,
  input  logic                 arst_n,
  input  uvi_pkg::cam_bus_t    cam,
  input  logic                 capture_en,
  output uvi_pkg::pixel_beat_t beat,
  output logic                 frame_done
);

  localparam int COORD_W = `UVI_COORD_W;
  // x must never reach this, counter would wrap
  localparam logic [COORD_W-1:0] X_LIMIT = COORD_W'((2 ** COORD_W) - 1);

  // Input stage
  logic                fv_q;
  logic                lv_q;
  logic                en_q;
  uvi_pkg::rgb_pixel_t rgb_q;
  // Delayed copies for edge detection
  logic                fv_d;
  logic                lv_d;

  logic                capturing;
  logic [COORD_W-1:0]  x_cnt;
  logic [COORD_W-1:0]  y_cnt;

  // Output stage
  logic                beat_valid_q;
  logic                beat_fv_q;
  logic [COORD_W-1:0]  beat_x_q;
  logic [COORD_W-1:0]  beat_y_q;
  uvi_pkg::rgb_pixel_t beat_rgb_q;

  logic fv_rise;
  logic fv_fall;
  logic line_end;
  logic capture_now;
  logic pix_take;

  // ==============================
  // Input register
  // ==============================

  // capture_en sampled together with the bus
  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      fv_q <= 1'b0;
      lv_q <= 1'b0;
      en_q <= 1'b0;
      fv_d <= 1'b0;
      lv_d <= 1'b0;
    end else begin
      fv_q <= cam.frame_valid;
      lv_q <= cam.line_valid;
      en_q <= capture_en;
      fv_d <= fv_q;
      lv_d <= lv_q;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    rgb_q <= cam.rgb;
  end

  assign fv_rise  = fv_q & ~fv_d;
  assign fv_fall  = ~fv_q & fv_d;
  assign line_end = ~lv_q & lv_d;

  // Decision at frame start applies to the first pixel too
  assign capture_now = fv_rise ? en_q : capturing;
  assign pix_take    = capture_now & fv_q & lv_q;

  // ==============================
  // Capture gate and counters
  // ==============================

  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      capturing <= 1'b0;
      x_cnt     <= '0;
      y_cnt     <= '0;
    end else begin
      // Only changes at frame start
      if (fv_rise) begin
        capturing <= en_q;
      end
      // Frame end wins over a line end in the same cycle
      if (fv_fall) begin
        x_cnt <= '0;
        y_cnt <= '0;
      end else if (capturing && fv_q && line_end) begin
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
      end else if (pix_take) begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // ==============================
  // Output register
  // ==============================

  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      beat_valid_q <= 1'b0;
      beat_fv_q    <= 1'b0;
      frame_done   <= 1'b0;
    end else begin
      beat_valid_q <= pix_take;
      beat_fv_q    <= fv_q & capture_now;
      // Skipped frames give no pulse
      frame_done   <= fv_fall & capturing;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    beat_x_q   <= x_cnt;
    beat_y_q   <= y_cnt;
    beat_rgb_q <= rgb_q;
  end

  always_comb begin
    beat.valid       = beat_valid_q;
    beat.frame_valid = beat_fv_q;
    beat.x           = beat_x_q;
    beat.y           = beat_y_q;
    beat.rgb         = beat_rgb_q;
  end

  // Line never longer than the counter range
  a_x_no_wrap : assert property (
    @(posedge CLOCK_50) disable iff (!arst_n)
    pix_take |-> (x_cnt < X_LIMIT)
  );

endmodule

/* capture/frame_sync.sv */
// FSM that drops captured beats until enough frame ends have passed after reset
`timescale 1ns/1ns
`include "uvi_consts.svh"

module frame_sync (
  input  logic                 CLOCK_50,
  input  logic                 arst_n,
  input  uvi_pkg::pixel_beat_t in_beat,
  output uvi_pkg::pixel_beat_t out_beat
);

  // Room to count one past the target
  localparam int EOF_W = $clog2(`UVI_SYNC_FRAMES + 1);
  localparam logic [EOF_W-1:0] EOF_LAST = EOF_W'(`UVI_SYNC_FRAMES - 1);

  uvi_pkg::sync_state_e state;
  logic [EOF_W-1:0]     eof_cnt;
  logic                 fv_d;
  logic                 eof_seen;

  logic                 out_valid_q;
  logic                 out_fv_q;
  uvi_pkg::pixel_beat_t payload_q;

  // Falling edge of the captured frame_valid
  assign eof_seen = fv_d & ~in_beat.frame_valid;

  // ==============================
  // Sync FSM
  // ==============================

  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      state   <= uvi_pkg::WAIT_EOF;
      eof_cnt <= '0;
      fv_d    <= 1'b0;
    end else begin
      fv_d <= in_beat.frame_valid;
      case (state)
        uvi_pkg::WAIT_EOF: begin
          if (eof_seen) begin
            eof_cnt <= eof_cnt + 1'b1;
            // Next frame starts clean
            if (eof_cnt == EOF_LAST) begin
              state <= uvi_pkg::PASS;
            end
          end
        end
        // Stays here until the next reset
        uvi_pkg::PASS: begin
          state <= uvi_pkg::PASS;
        end
        default: begin
          state <= uvi_pkg::WAIT_EOF;
        end
      endcase
    end
  end

  // ==============================
  // Output stage
  // ==============================

  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      out_valid_q <= 1'b0;
      out_fv_q    <= 1'b0;
    end else begin
      out_valid_q <= (state == uvi_pkg::PASS) & in_beat.valid;
      out_fv_q    <= (state == uvi_pkg::PASS) & in_beat.frame_valid;
    end
  end

  // Coordinates and colour
  always_ff @(posedge CLOCK_50) begin
    payload_q <= in_beat;
  end

  always_comb begin
    out_beat             = payload_q;
    out_beat.valid       = out_valid_q;
    out_beat.frame_valid = out_fv_q;
  end

  // No valid output before every sync frame end was counted
  a_no_early_pixel : assert property (
    @(posedge CLOCK_50) disable iff (!arst_n)
    out_beat.valid |-> ((state == uvi_pkg::PASS) &&
                        (eof_cnt == EOF_W'(`UVI_SYNC_FRAMES)))
  );

endmodule

/* img_proc/gray_binarizer.sv */
// Two-stage gray conversion and window binarisation of the synced pixel stream
`timescale 1ns/1ns
`include "uvi_consts.svh"

module gray_binarizer (
  input  logic                    CLOCK_50,
  input  logic                    arst_n,
  input  uvi_pkg::pixel_beat_t    in_beat,
  input  uvi_pkg::threshold_cfg_t thresholds,
  output uvi_pkg::mono_beat_t     gray_out,
  output uvi_pkg::mono_beat_t     bin_out
);

  localparam int PIX_W = `UVI_PIX_W;
  // Weighted sum up to 4 x 255
  localparam int SUM_W = PIX_W + `UVI_GRAY_SHIFT;

  logic [SUM_W-1:0] sum_c;
  logic [PIX_W-1:0] gray_c;
  logic             in_window;

  // Stage one
  logic             s1_valid;
  logic [PIX_W-1:0] s1_gray;

  // Stage two
  logic             s2_valid;
  logic [PIX_W-1:0] s2_gray;
  logic [PIX_W-1:0] s2_bin;

  // ==============================
  // Stage one, gray
  // ==============================

  // (R + 2G + B) / 4, truncated
  assign sum_c = SUM_W'(in_beat.rgb.red)   * SUM_W'(`UVI_GRAY_WR)
               + SUM_W'(in_beat.rgb.green) * SUM_W'(`UVI_GRAY_WG)
               + SUM_W'(in_beat.rgb.blue)  * SUM_W'(`UVI_GRAY_WB);
  assign gray_c = PIX_W'(sum_c >> `UVI_GRAY_SHIFT);

  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_beat.valid;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    s1_gray <= gray_c;
  end

  // ==============================
  // Stage two, threshold window
  // ==============================

  // Both bounds inclusive
  assign in_window = (s1_gray >= thresholds.low) && (s1_gray <= thresholds.high);

  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    s2_gray <= s1_gray;
    s2_bin  <= in_window ? '1 : '0;
  end

  // Gray and binary leave together
  always_comb begin
    gray_out.valid = s2_valid;
    gray_out.value = s2_gray;
    bin_out.valid  = s2_valid;
    bin_out.value  = s2_bin;
  end

  // Binary is a full byte mask and belongs to the gray it leaves with
  a_bin_mask : assert property (
    @(posedge CLOCK_50) disable iff (!arst_n)
    bin_out.valid |-> (bin_out.value == '0 || bin_out.value == '1) &&
      ((bin_out.value == '1) == ((gray_out.value >= $past(thresholds.low)) &&
                                 (gray_out.value <= $past(thresholds.high))))
  );

endmodule

/* src/frame_rate_meter.sv */
// Window timer counting frame_done pulses per window, with heartbeat LED toggle
`timescale 1ns/1ns
`include "uvi_consts.svh"

module frame_rate_meter #(
  parameter int rate_period = `UVI_RATE_PERIOD
) (
  input  logic                  CLOCK_50,
  input  logic                  arst_n,
  input  logic                  frame_done,
  output logic [`UVI_CNT_W-1:0] rate,
  output logic                  pulse_led
);

  localparam int TMR_W = (rate_period > 1) ? $clog2(rate_period) : 1;
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(rate_period - 1);

  logic [TMR_W-1:0]      tmr;
  logic [`UVI_CNT_W-1:0] frame_cnt;
  logic [`UVI_CNT_W-1:0] frame_cnt_nxt;
  logic                  win_end;

  assign win_end = (tmr == TMR_LAST);
  // Pulse in the last cycle still belongs to this window
  assign frame_cnt_nxt = frame_cnt + `UVI_CNT_W'(frame_done);

  // ==============================
  // Window timer and counter
  // ==============================

  // First window opens right after reset release
  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      tmr       <= '0;
      frame_cnt <= '0;
      rate      <= '0;
      pulse_led <= 1'b0;
    end else begin
      if (win_end) begin
        tmr       <= '0;
        frame_cnt <= '0;
        rate      <= frame_cnt_nxt;
        // Heartbeat, one toggle per window
        pulse_led <= ~pulse_led;
      end else begin
        tmr       <= tmr + 1'b1;
        frame_cnt <= frame_cnt_nxt;
      end
    end
  end

endmodule

/* src/uvispace_top.sv */
// Pixel pipeline top level with capture, sync, gray/binary and frame rate blocks
`timescale 1ns/1ns
`include "uvi_consts.svh"

module uvispace_top #(
  parameter int rate_period = `UVI_RATE_PERIOD
) (
  input  logic                    CLOCK_50,
  input  logic                    arst_n,
  // Sensor side
  input  uvi_pkg::cam_bus_t       cam,
  input  logic                    capture_en,
  input  uvi_pkg::threshold_cfg_t thresholds,
  // Processed streams
  output uvi_pkg::pixel_beat_t    sync_pixel,
  output uvi_pkg::mono_beat_t     gray_out,
  output uvi_pkg::mono_beat_t     bin_out,
  // Frame rate
  output logic [`UVI_CNT_W-1:0]   rate,
  output logic                    pulse_led
);

  uvi_pkg::pixel_beat_t cap_beat;
  logic                 frame_done;

  // ==============================
  // Capture and sync
  // ==============================

  // Sensor to beat, 2 cycles
  camera_capture capture_i (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .cam        (cam),
    .capture_en (capture_en),
    .beat       (cap_beat),
    .frame_done (frame_done)
  );

  // One more cycle, sync_pixel at 3
  frame_sync sync_i (
    .CLOCK_50 (CLOCK_50),
    .arst_n   (arst_n),
    .in_beat  (cap_beat),
    .out_beat (sync_pixel)
  );

  // ==============================
  // Processing and rate
  // ==============================

  // Gray and binary at 5 cycles from the sensor
  gray_binarizer binarizer_i (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .in_beat    (sync_pixel),
    .thresholds (thresholds),
    .gray_out   (gray_out),
    .bin_out    (bin_out)
  );

  frame_rate_meter #(
    .rate_period (rate_period)
  ) rate_i (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .frame_done (frame_done),
    .rate       (rate),
    .pulse_led  (pulse_led)
  );

endmodule

/* verif/uvi_checker.sv */
// Reference model of the pixel pipeline and comparison of every DUT output
`timescale 1ns/1ns
`include "uvi_consts.svh"

module uvi_checker #(
  parameter int rate_period = 2000
) (
  input  logic                    CLOCK_50,
  input  logic                    arst_n,
  // Stimulus as seen by the DUT
  input  uvi_pkg::cam_bus_t       cam,
  input  logic                    capture_en,
  input  uvi_pkg::threshold_cfg_t thresholds,
  // DUT outputs
  input  uvi_pkg::pixel_beat_t    sync_pixel,
  input  uvi_pkg::mono_beat_t     gray_out,
  input  uvi_pkg::mono_beat_t     bin_out,
  input  logic [`UVI_CNT_W-1:0]   rate,
  input  logic                    pulse_led,
  output int                      error_count,
  output int                      check_count
);

  // Expected beat per sensor sample, index is the age in cycles
  uvi_pkg::pixel_beat_t    exp_pix [0:5];
  logic                    fd_pipe [0:2];
  // Window used by the second processing stage
  uvi_pkg::threshold_cfg_t thr_prev;

  logic                    prev_fv;
  logic                    prev_lv;
  logic                    capturing;
  int                      col;
  int                      row;
  int                      eofs;
  int                      since_rst;
  int                      win_frames;
  logic [`UVI_CNT_W-1:0]   exp_rate;
  logic                    exp_led;
  logic                    first_seen;

  int errors = 0;
  int checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 'h%0h, expected 'h%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic reset_model();
    int d;
    for (d = 0; d < 6; d++) begin
      exp_pix[d] = '0;
    end
    for (d = 0; d < 3; d++) begin
      fd_pipe[d] = 1'b0;
    end
    prev_fv    = 1'b0;
    prev_lv    = 1'b0;
    capturing  = 1'b0;
    col        = 0;
    row        = 0;
    eofs       = 0;
    since_rst  = 0;
    win_frames = 0;
    exp_rate   = '0;
    exp_led    = 1'b0;
    first_seen = 1'b0;
  endtask

  // ==============================
  // Capture and sync model
  // ==============================

  task automatic model_step();
    uvi_pkg::pixel_beat_t b;
    logic                 fd;
    int                   d;
    b  = '0;
    fd = 1'b0;
    // Capture decided by the enable at the first sample of a frame
    if (cam.frame_valid && !prev_fv) begin
      capturing = capture_en;
    end
    // Frame flag of a captured frame, gated by the sync too
    if (capturing && cam.frame_valid) begin
      b.frame_valid = (eofs >= `UVI_SYNC_FRAMES);
    end
    if (capturing && cam.frame_valid && cam.line_valid) begin
      // Passed only once enough captured frames have ended
      b.valid = (eofs >= `UVI_SYNC_FRAMES);
      b.x     = `UVI_COORD_W'(col);
      b.y     = `UVI_COORD_W'(row);
      b.rgb   = cam.rgb;
      col++;
    end
    if (!cam.frame_valid && prev_fv) begin
      fd = capturing;
      if (capturing) begin
        eofs++;
      end
      col = 0;
      row = 0;
    end else if (cam.frame_valid && !cam.line_valid && prev_lv) begin
      col = 0;
      row++;
    end
    prev_fv = cam.frame_valid;
    prev_lv = cam.line_valid;
    for (d = 5; d > 0; d--) begin
      exp_pix[d] = exp_pix[d-1];
    end
    fd_pipe[2] = fd_pipe[1];
    fd_pipe[1] = fd_pipe[0];
    exp_pix[0] = b;
    fd_pipe[0] = fd;
  endtask

  // Window ends every rate_period cycles after reset release
  task automatic rate_step();
    if (since_rst > 0 && (since_rst % rate_period) == 0) begin
      exp_rate   = `UVI_CNT_W'(win_frames);
      exp_led    = ~exp_led;
      win_frames = 0;
    end
    // Pulse seen now is counted at the next edge
    if (fd_pipe[2]) begin
      win_frames++;
    end
    since_rst++;
  endtask

  // ==============================
  // Output comparison
  // ==============================

  task automatic compare_outputs();
    uvi_pkg::pixel_beat_t s;
    uvi_pkg::pixel_beat_t g;
    int                   gray;
    logic [7:0]           bin;
    s    = exp_pix[3];
    g    = exp_pix[5];
    gray = (int'(g.rgb.red) + 2 * int'(g.rgb.green) + int'(g.rgb.blue)) / 4;
    bin  = (gray >= int'(thr_prev.low) && gray <= int'(thr_prev.high)) ? 8'hff : 8'h00;
    check_value("sync_pixel.valid", 32'(sync_pixel.valid), 32'(s.valid));
    check_value("sync_pixel.frame_valid", 32'(sync_pixel.frame_valid),
                32'(s.frame_valid));
    if (s.valid) begin
      check_value("sync_pixel.x", 32'(sync_pixel.x), 32'(s.x));
      check_value("sync_pixel.y", 32'(sync_pixel.y), 32'(s.y));
      check_value("sync_pixel.rgb", 32'(sync_pixel.rgb), 32'(s.rgb));
    end
    // First synced pixel opens a frame
    if (sync_pixel.valid && !first_seen) begin
      first_seen = 1'b1;
      checks++;
      if (sync_pixel.x != 0 || sync_pixel.y != 0) begin
        errors++;
        $display("ERROR: first synced pixel is not the top left pixel of a frame");
      end
    end
    check_value("gray_out.valid", 32'(gray_out.valid), 32'(g.valid));
    check_value("bin_out.valid", 32'(bin_out.valid), 32'(g.valid));
    if (g.valid) begin
      check_value("gray_out.value", 32'(gray_out.value), 32'(gray));
      check_value("bin_out.value", 32'(bin_out.value), 32'(bin));
    end
    check_value("rate", 32'(rate), 32'(exp_rate));
    check_value("pulse_led", 32'(pulse_led), 32'(exp_led));
  endtask

  // Inputs and outputs both settled mid-cycle
  always @(negedge CLOCK_50) begin
    if (!arst_n) begin
      reset_model();
    end else begin
      model_step();
      rate_step();
    end
    compare_outputs();
    thr_prev = thresholds;
  end

endmodule

/* verif/tb_uvispace.sv */
// Testbench top with clock, reset, random frame stimulus, timeout and final verdict
`timescale 1ns/1ns
`include "uvi_consts.svh"

module tb_uvispace;

  localparam int RATE_PERIOD = 2000;
  localparam int FRAMES      = 12;
  localparam int LINE_PIX    = 8;
  localparam int LINES       = 4;
  localparam int BLANK_MIN   = 2;
  localparam int BLANK_MAX   = 9;
  // Worst case, every line followed by the longest blanking
  localparam int FRAME_MAX   = LINES * (LINE_PIX + BLANK_MAX) + BLANK_MAX;
  localparam int CYCLE_LIMIT = FRAMES * FRAME_MAX + RATE_PERIOD;

  logic                    CLOCK_50;
  logic                    arst_n;
  uvi_pkg::cam_bus_t       cam;
  logic                    capture_en;
  uvi_pkg::threshold_cfg_t thresholds;
  uvi_pkg::pixel_beat_t    sync_pixel;
  uvi_pkg::mono_beat_t     gray_out;
  uvi_pkg::mono_beat_t     bin_out;
  logic [`UVI_CNT_W-1:0]   rate;
  logic                    pulse_led;

  int     error_count;
  int     check_count;
  int     cycles = 0;
  integer seed = 32'h1a4593ff;

  uvispace_top #(
    .rate_period (RATE_PERIOD)
  ) dut_i (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .cam        (cam),
    .capture_en (capture_en),
    .thresholds (thresholds),
    .sync_pixel (sync_pixel),
    .gray_out   (gray_out),
    .bin_out    (bin_out),
    .rate       (rate),
    .pulse_led  (pulse_led)
  );

  uvi_checker #(
    .rate_period (RATE_PERIOD)
  ) checker_i (
    .CLOCK_50    (CLOCK_50),
    .arst_n      (arst_n),
    .cam         (cam),
    .capture_en  (capture_en),
    .thresholds  (thresholds),
    .sync_pixel  (sync_pixel),
    .gray_out    (gray_out),
    .bin_out     (bin_out),
    .rate        (rate),
    .pulse_led   (pulse_led),
    .error_count (error_count),
    .check_count (check_count)
  );

  // ==============================
  // Clock and timeout
  // ==============================

  initial begin
    CLOCK_50 = 1'b0;
    forever #10 CLOCK_50 = ~CLOCK_50;
  end

  always @(posedge CLOCK_50) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("ERROR: run did not reach a rate window end within %0d cycles", CYCLE_LIMIT);
      $display("Summary: %0d checks, %0d errors, 1 timeout", check_count, error_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ==============================
  // Stimulus helpers
  // ==============================

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  // High about three times in four
  function automatic logic pick_enable();
    int r;
    r = $random(seed);
    return (r & 3) != 0;
  endfunction

  // One sensor sample on the next rising edge
  task automatic drive_sample(input logic fv, input logic lv);
    uvi_pkg::cam_bus_t s;
    s.frame_valid = fv;
    s.line_valid  = lv;
    s.rgb         = 24'($random(seed));
    @(posedge CLOCK_50);
    cam <= s;
  endtask

  // Frame blanking, new enable and window on its first cycle
  task automatic blank_frame(input int n);
    uvi_pkg::threshold_cfg_t t;
    logic [7:0]              a;
    logic [7:0]              b;
    int                      i;
    a = 8'($random(seed));
    b = 8'($random(seed));
    t.low  = (a <= b) ? a : b;
    t.high = (a <= b) ? b : a;
    for (i = 0; i < n; i++) begin
      drive_sample(1'b0, 1'b0);
      if (i == 0) begin
        capture_en <= pick_enable();
        thresholds <= t;
      end
    end
  endtask

  // Enable may also move mid-frame, which must not cut the frame
  task automatic blank_line(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      drive_sample(1'b1, 1'b0);
      if (i == 0) begin
        capture_en <= pick_enable();
      end
    end
  endtask

  task automatic send_frame();
    int line;
    int pix;
    for (line = 0; line < LINES; line++) begin
      for (pix = 0; pix < LINE_PIX; pix++) begin
        drive_sample(1'b1, 1'b1);
      end
      if (line < LINES - 1) begin
        blank_line(rand_range(BLANK_MIN, BLANK_MAX));
      end
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    int   f;
    logic led_start;
    cam        = '0;
    capture_en = 1'b0;
    thresholds = '0;
    arst_n     = 1'b0;
    repeat (2) @(posedge CLOCK_50);
    arst_n <= 1'b1;
    blank_frame(rand_range(BLANK_MIN, BLANK_MAX));
    for (f = 0; f < FRAMES; f++) begin
      send_frame();
      blank_frame(rand_range(BLANK_MIN, BLANK_MAX));
    end
    // Idle until the first rate window closes
    led_start = pulse_led;
    while (pulse_led == led_start) begin
      @(posedge CLOCK_50);
    end
    repeat (4) @(posedge CLOCK_50);
    $display("Summary: %0d checks, %0d errors, 0 timeouts", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+common
common/uvi_pkg.sv
capture/camera_capture.sv
capture/frame_sync.sv
img_proc/gray_binarizer.sv
src/frame_rate_meter.sv
src/uvispace_top.sv
verif/uvi_checker.sv
verif/tb_uvispace.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_uvispace
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
